/* tests/id_stage_stim.txt */
# inst reg1_data reg2_data | ex: we waddr wdata | mem: we waddr wdata
# expected: rf_rd1 rf_rd2 ex_ctrl reg1_o reg2_o, all hex
00221824 a1a1a1a1 b2b2b2b2 0 00 00000000 0 00 00000000 21 22 484007 a1a1a1a1 b2b2b2b2
00853025 c3c3c3c3 d4d4d4d4 0 00 00000000 0 00 00000000 24 25 4a400d c3c3c3c3 d4d4d4d4
00e84826 12345678 9abcdef0 0 00 00000000 0 00 00000000 27 28 4c4013 12345678 9abcdef0
014b6027 0f0f0f0f f0f0f0f0 0 00 00000000 0 00 00000000 2a 2b 4e4019 0f0f0f0f f0f0f0f0
01ae7804 00000004 80000001 0 00 00000000 0 00 00000000 2d 2e f8801f 00000004 80000001
02119006 00000008 7fffffff 0 00 00000000 0 00 00000000 30 31 048025 00000008 7fffffff
0274a807 0000001f 87654321 0 00 00000000 0 00 00000000 33 34 06802b 0000001f 87654321
3422beef 55555555 66666666 0 00 00000000 0 00 00000000 21 02 4a4005 55555555 0000beef
306400ff 77777777 12121212 0 00 00000000 0 00 00000000 23 04 484009 77777777 000000ff
38a68001 88888888 34343434 0 00 00000000 0 00 00000000 25 06 4c400d 88888888 00008001
3c071234 00000000 56565656 0 00 00000000 0 00 00000000 20 07 4a400f 00000000 12340000
00094140 78787878 abcdef01 0 00 00000000 0 00 00000000 00 29 f88011 00000005 abcdef01
000b57c2 9a9a9a9a 13579bdf 0 00 00000000 0 00 00000000 00 2b 048015 0000001f 13579bdf
000d6043 bcbcbcbc 80000000 0 00 00000000 0 00 00000000 00 2d 068019 00000001 80000000
00221825 11111111 22222222 1 01 e0e0e0e0 1 01 f0000001 21 22 4a4007 e0e0e0e0 22222222
00642824 33333333 44444444 1 07 dead0007 1 04 0000cafe 23 24 48400b 33333333 0000cafe
00c74026 66666666 77777777 0 06 bad00006 0 07 bad00007 26 27 4c4011 66666666 77777777
00434827 21212121 31313131 1 03 0e0e0e0e 1 02 0d0d0d0d 22 23 4e4013 0d0d0d0d 0e0e0e0e
312a1234 90909090 a0a0a0a0 1 0a ffffffff 1 09 09090909 29 0a 484015 09090909 00001234
0000000f 5a5a5a5a a5a5a5a5 0 00 00000000 0 00 00000000 00 00 4a0001 00000000 00000000
cc810010 5a5a5a5a a5a5a5a5 1 04 feedf00d 0 00 00000000 04 01 000001 00000000 00000000
fca63800 5a5a5a5a a5a5a5a5 0 00 00000000 0 00 00000000 05 06 00000e 00000000 00000000

/* sim.f */
+incdir+hdl
hdl/mips_pkg.sv
hdl/inst_decoder.sv
hdl/operand_fwd.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
tests/id_stage_assertions.sv
tests/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_id_stage \
    -f sim.f -o tb_id_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_id_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

/* tests/tb_id_stage.sv */
`include "mips_consts.svh"

`default_nettype none

module tb_id_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam string STIM_FILE = "tests/id_stage_stim.txt";

    // field lsbs inside the 25-bit ex_ctrl column of the stim file
    localparam int COL_ALU_OP_LSB  = 17;
    localparam int COL_ALU_SEL_LSB = 14;
    localparam int COL_WD_LSB      = 1;

    // one line of the stim file
    typedef struct packed {
        logic [`MIPS_INST_W-1:0] inst;
        logic [`MIPS_DATA_W-1:0] reg1_data;
        logic [`MIPS_DATA_W-1:0] reg2_data;
        wb_fwd_t                 ex_fwd;
        wb_fwd_t                 mem_fwd;
        rf_read_t                exp_rd1;
        rf_read_t                exp_rd2;
        ex_ctrl_t                exp_ctrl;
        logic [`MIPS_DATA_W-1:0] exp_reg1;
        logic [`MIPS_DATA_W-1:0] exp_reg2;
    } stim_vec_t;

    logic                    clk;
    logic                    rst_n_i;
    logic [`MIPS_INST_W-1:0] inst_i;
    logic [`MIPS_DATA_W-1:0] reg1_data_i;
    logic [`MIPS_DATA_W-1:0] reg2_data_i;
    wb_fwd_t                 ex_fwd_i;
    wb_fwd_t                 mem_fwd_i;
    rf_read_t                rf_rd1_o;
    rf_read_t                rf_rd2_o;
    ex_ctrl_t                ex_ctrl_o;
    logic [`MIPS_DATA_W-1:0] reg1_o;
    logic [`MIPS_DATA_W-1:0] reg2_o;

    stim_vec_t vecs[$];
    bit        vecs_loaded;

    id_stage UUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .rf_rd1_o    (rf_rd1_o),
        .rf_rd2_o    (rf_rd2_o),
        .ex_ctrl_o   (ex_ctrl_o),
        .reg1_o      (reg1_o),
        .reg2_o      (reg2_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            fail_run($sformatf("FAIL %s expected 0x%08h got 0x%08h", name, exp, act));
        end
    endtask

    // alu_op at 24:17, alu_sel at 16:14, wd at 5:1, wreg at 0
    function automatic ex_ctrl_t ctrl_from_column(input logic [31:0] col);
        ex_ctrl_t c;
        c.alu_op  = alu_op_e'(col[COL_ALU_OP_LSB +: $bits(alu_op_e)]);
        c.alu_sel = alu_sel_e'(col[COL_ALU_SEL_LSB +: $bits(alu_sel_e)]);
        c.wd      = col[COL_WD_LSB +: `MIPS_REG_ADDR_W];
        c.wreg    = col[0];
        return c;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        stim_vec_t   v;
        logic [31:0] fld [14];
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            fail_run({"cannot open stimulus file ", STIM_FILE});
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // skip column notes and blank lines
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                        fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
            if (n != 14) begin
                fail_run({"stimulus line has the wrong number of fields: ", line});
            end
            v.inst          = fld[0];
            v.reg1_data     = fld[1];
            v.reg2_data     = fld[2];
            v.ex_fwd.we     = fld[3][0];
            v.ex_fwd.waddr  = fld[4][`MIPS_REG_ADDR_W-1:0];
            v.ex_fwd.wdata  = fld[5];
            v.mem_fwd.we    = fld[6][0];
            v.mem_fwd.waddr = fld[7][`MIPS_REG_ADDR_W-1:0];
            v.mem_fwd.wdata = fld[8];
            v.exp_rd1       = fld[9][$bits(rf_read_t)-1:0];
            v.exp_rd2       = fld[10][$bits(rf_read_t)-1:0];
            v.exp_ctrl      = ctrl_from_column(fld[11]);
            v.exp_reg1      = fld[12];
            v.exp_reg2      = fld[13];
            vecs.push_back(v);
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            fail_run("stimulus file holds no vectors");
        end
        vecs_loaded = 1'b1;
    endtask

    task automatic apply_vector(input stim_vec_t v);
        inst_i      <= v.inst;
        reg1_data_i <= v.reg1_data;
        reg2_data_i <= v.reg2_data;
        ex_fwd_i    <= v.ex_fwd;
        mem_fwd_i   <= v.mem_fwd;
    endtask

    // read requests are combinational, same cycle
    task automatic check_requests(input int idx, input stim_vec_t v);
        expect_equal($sformatf("rf_rd1_o (vector %0d)", idx), 32'(v.exp_rd1), 32'(rf_rd1_o));
        expect_equal($sformatf("rf_rd2_o (vector %0d)", idx), 32'(v.exp_rd2), 32'(rf_rd2_o));
    endtask

    task automatic check_registered(input int idx, input stim_vec_t v);
        expect_equal($sformatf("ex_ctrl_o (vector %0d)", idx), 32'(v.exp_ctrl), 32'(ex_ctrl_o));
        expect_equal($sformatf("reg1_o (vector %0d)", idx), v.exp_reg1, reg1_o);
        expect_equal($sformatf("reg2_o (vector %0d)", idx), v.exp_reg2, reg2_o);
    endtask

    initial begin : watchdog
        int cycles;
        wait (vecs_loaded);
        cycles = RESET_CYCLES + vecs.size() + 20;
        #(cycles * CLK_PERIOD);
        fail_run($sformatf("timeout: the test did not finish within %0d cycles", cycles));
    end

    initial begin : stimulus
        rst_n_i     = 1'b0;
        inst_i      = '0;
        reg1_data_i = '0;
        reg2_data_i = '0;
        ex_fwd_i    = '0;
        mem_fwd_i   = '0;
        vecs_loaded = 1'b0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        // bubble with zero operands right after release
        @(negedge clk);
        expect_equal("ex_ctrl_o (after reset)", 32'h0, 32'(ex_ctrl_o));
        expect_equal("reg1_o (after reset)", 32'h0, reg1_o);
        expect_equal("reg2_o (after reset)", 32'h0, reg2_o);
        // one vector per cycle, ID/EX lags by one edge
        for (int i = 0; i < vecs.size(); i++) begin
            @(posedge clk);
            apply_vector(vecs[i]);
            @(negedge clk);
            check_requests(i, vecs[i]);
            if (i > 0) begin
                check_registered(i - 1, vecs[i - 1]);
            end
        end
        @(negedge clk);
        check_registered(vecs.size() - 1, vecs[vecs.size() - 1]);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/id_stage_assertions.sv */
`include "mips_consts.svh"

`default_nettype none

module id_stage_assertions (
    input wire logic                    clk,
    input wire logic                    rst_n_i,
    input wire logic [`MIPS_DATA_W-1:0] reg1_data_i,
    input wire mips_pkg::wb_fwd_t       ex_fwd_i,
    input wire mips_pkg::wb_fwd_t       mem_fwd_i,
    input wire mips_pkg::rf_read_t      rf_rd1_o,
    input wire mips_pkg::rf_read_t      rf_rd2_o,
    input wire mips_pkg::ex_ctrl_t      ex_ctrl_o,
    input wire logic [`MIPS_DATA_W-1:0] reg1_o,
    input wire logic [`MIPS_DATA_W-1:0] reg2_o,
    input wire logic [`MIPS_DATA_W-1:0] dec_imm
);

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    logic zero_fwd;

    // a later stage writing $zero would shadow the register file
    assign zero_fwd = (ex_fwd_i.we && ex_fwd_i.waddr == `MIPS_NOP_REG)
                   || (mem_fwd_i.we && mem_fwd_i.waddr == `MIPS_NOP_REG);

    a_reset_bubble: assert property (@(posedge clk) !rst_n_i |->
        !ex_ctrl_o.wreg && ex_ctrl_o.alu_op == alu_nop && ex_ctrl_o.alu_sel == sel_nop)
        else $error("ID/EX register is not a bubble during reset");

    // idle port passes the immediate on
    a_idle_port1: assert property (@(posedge clk) disable iff (!rst_n_i)
        rst_n_i && !rf_rd1_o.re |=> reg1_o == $past(dec_imm))
        else $error("reg1_o does not hold the immediate of an idle port");

    a_idle_port2: assert property (@(posedge clk) disable iff (!rst_n_i)
        rst_n_i && !rf_rd2_o.re |=> reg2_o == $past(dec_imm))
        else $error("reg2_o does not hold the immediate of an idle port");

    a_zero_read: assert property (@(posedge clk) disable iff (!rst_n_i)
        rst_n_i && rf_rd1_o.re && rf_rd1_o.addr == `MIPS_NOP_REG && !zero_fwd
        |=> reg1_o == $past(reg1_data_i))
        else $error("read of $zero did not return the register file data");

endmodule

bind id_stage id_stage_assertions u_assertions (.*);

`default_nettype wire

/* hdl/id_stage.sv */
`include "mips_consts.svh"

`default_nettype none

module id_stage (
    input  wire logic                     clk,
    input  wire logic                     rst_n_i,
    input  wire logic [`MIPS_INST_W-1:0]  inst_i,
    input  wire logic [`MIPS_DATA_W-1:0]  reg1_data_i,
    input  wire logic [`MIPS_DATA_W-1:0]  reg2_data_i,
    input  wire mips_pkg::wb_fwd_t        ex_fwd_i,
    input  wire mips_pkg::wb_fwd_t        mem_fwd_i,
    output mips_pkg::rf_read_t            rf_rd1_o,
    output mips_pkg::rf_read_t            rf_rd2_o,
    output mips_pkg::ex_ctrl_t            ex_ctrl_o,
    output logic [`MIPS_DATA_W-1:0]       reg1_o,
    output logic [`MIPS_DATA_W-1:0]       reg2_o
);

    import mips_pkg::*;

    ex_ctrl_t                dec_ctrl;
    logic [`MIPS_DATA_W-1:0] dec_imm;
    logic [`MIPS_DATA_W-1:0] opnd1;
    logic [`MIPS_DATA_W-1:0] opnd2;

    // read requests leave the stage combinationally
    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (dec_ctrl),
        .rd1_o  (rf_rd1_o),
        .rd2_o  (rf_rd2_o),
        .imm_o  (dec_imm)
    );

    // operand 1, rs side
    operand_fwd u_fwd1 (
        .rd_i      (rf_rd1_o),
        .rf_data_i (reg1_data_i),
        .imm_i     (dec_imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (opnd1)
    );

    // operand 2, rt side
    operand_fwd u_fwd2 (
        .rd_i      (rf_rd2_o),
        .rf_data_i (reg2_data_i),
        .imm_i     (dec_imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (opnd2)
    );

    id_ex_reg u_id_ex (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ctrl_i  (dec_ctrl),
        .reg1_i  (opnd1),
        .reg2_i  (opnd2),
        .ctrl_o  (ex_ctrl_o),
        .reg1_o  (reg1_o),
        .reg2_o  (reg2_o)
    );

endmodule

`default_nettype wire

/* hdl/id_ex_reg.sv */
`include "mips_consts.svh"

`default_nettype none

module id_ex_reg (
    input  wire logic                     clk,
    input  wire logic                     rst_n_i,
    input  wire mips_pkg::ex_ctrl_t       ctrl_i,
    input  wire logic [`MIPS_DATA_W-1:0]  reg1_i,
    input  wire logic [`MIPS_DATA_W-1:0]  reg2_i,
    output mips_pkg::ex_ctrl_t            ctrl_o,
    output logic [`MIPS_DATA_W-1:0]       reg1_o,
    output logic [`MIPS_DATA_W-1:0]       reg2_o
);

    import mips_pkg::*;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // bubble into EX
            ctrl_o.alu_op  <= alu_nop;
            ctrl_o.alu_sel <= sel_nop;
            ctrl_o.wd      <= `MIPS_NOP_REG;
            ctrl_o.wreg    <= 1'b0;
            reg1_o         <= '0;
            reg2_o         <= '0;
        end else begin
            ctrl_o <= ctrl_i;
            reg1_o <= reg1_i;
            reg2_o <= reg2_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/operand_fwd.sv */
`include "mips_consts.svh"

`default_nettype none

module operand_fwd (
    input  wire mips_pkg::rf_read_t        rd_i,
    input  wire logic [`MIPS_DATA_W-1:0]   rf_data_i,
    input  wire logic [`MIPS_DATA_W-1:0]   imm_i,
    input  wire mips_pkg::wb_fwd_t         ex_fwd_i,
    input  wire mips_pkg::wb_fwd_t         mem_fwd_i,
    output logic [`MIPS_DATA_W-1:0]        operand_o
);

    logic ex_hit;
    logic mem_hit;

    // a later stage is about to write the register we read
    assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.waddr == rd_i.addr);
    assign mem_hit = mem_fwd_i.we && (mem_fwd_i.waddr == rd_i.addr);

    always_comb begin
        if (!rd_i.re) begin
            // idle port carries the immediate
            operand_o = imm_i;
        end else if (ex_hit) begin
            // youngest result wins
            operand_o = ex_fwd_i.wdata;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
`include "mips_consts.svh"

`default_nettype none

module inst_decoder (
    input  wire logic [`MIPS_INST_W-1:0] inst_i,
    output mips_pkg::ex_ctrl_t           ctrl_o,
    output mips_pkg::rf_read_t           rd1_o,
    output mips_pkg::rf_read_t           rd2_o,
    output logic [`MIPS_DATA_W-1:0]      imm_o
);

    import mips_pkg::*;

    opcode_e                     op;
    funct_e                      fn;
    logic [`MIPS_REG_ADDR_W-1:0] rs;
    logic [`MIPS_REG_ADDR_W-1:0] rt;
    logic [`MIPS_REG_ADDR_W-1:0] rd;
    logic [`MIPS_SHAMT_W-1:0]    shamt;
    logic [`MIPS_IMM_W-1:0]      imm16;

    // instruction fields
    assign op    = opcode_e'(inst_i[`MIPS_OP_LSB +: $bits(opcode_e)]);
    assign fn    = funct_e'(inst_i[$bits(funct_e)-1:0]);
    assign rs    = inst_i[`MIPS_RS_LSB +: `MIPS_REG_ADDR_W];
    assign rt    = inst_i[`MIPS_RT_LSB +: `MIPS_REG_ADDR_W];
    assign rd    = inst_i[`MIPS_RD_LSB +: `MIPS_REG_ADDR_W];
    assign shamt = inst_i[`MIPS_SHAMT_LSB +: `MIPS_SHAMT_W];
    assign imm16 = inst_i[`MIPS_IMM_W-1:0];

    always_comb begin
        // defaults give a bubble writing nowhere
        ctrl_o.alu_op  = alu_nop;
        ctrl_o.alu_sel = sel_nop;
        ctrl_o.wd      = rd;
        ctrl_o.wreg    = 1'b0;
        // addresses follow rs/rt even when the port is idle
        rd1_o.re       = 1'b0;
        rd1_o.addr     = rs;
        rd2_o.re       = 1'b0;
        rd2_o.addr     = rt;
        imm_o          = '0;

        case (op)
            op_special: begin
                case (fn)
                    fn_and, fn_or, fn_xor, fn_nor, fn_sllv, fn_srlv, fn_srav: begin
                        if (shamt == '0) begin
                            ctrl_o.wreg = 1'b1;
                            rd1_o.re    = 1'b1;
                            rd2_o.re    = 1'b1;
                            case (fn)
                                fn_and:  ctrl_o.alu_op = alu_and;
                                fn_or:   ctrl_o.alu_op = alu_or;
                                fn_xor:  ctrl_o.alu_op = alu_xor;
                                fn_nor:  ctrl_o.alu_op = alu_nor;
                                fn_sllv: ctrl_o.alu_op = alu_sll;
                                fn_srlv: ctrl_o.alu_op = alu_srl;
                                default: ctrl_o.alu_op = alu_sra;
                            endcase
                            // variable shifts take the amount from rs
                            if (fn == fn_sllv || fn == fn_srlv || fn == fn_srav) begin
                                ctrl_o.alu_sel = sel_shift;
                            end else begin
                                ctrl_o.alu_sel = sel_logic;
                            end
                        end
                    end
                    // shift by shamt, only legal with rs field clear
                    fn_sll, fn_srl, fn_sra: begin
                        if (rs == '0) begin
                            ctrl_o.wreg    = 1'b1;
                            ctrl_o.alu_sel = sel_shift;
                            rd2_o.re       = 1'b1;
                            imm_o          = {{(`MIPS_DATA_W-`MIPS_SHAMT_W){1'b0}}, shamt};
                            case (fn)
                                fn_sll:  ctrl_o.alu_op = alu_sll;
                                fn_srl:  ctrl_o.alu_op = alu_srl;
                                default: ctrl_o.alu_op = alu_sra;
                            endcase
                        end
                    end
                    // in-order core, so sync behaves as a nop
                    fn_sync: begin
                        if (shamt == '0) begin
                            ctrl_o.wreg   = 1'b1;
                            ctrl_o.alu_op = alu_or;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            op_ori, op_andi, op_xori: begin
                ctrl_o.wreg    = 1'b1;
                ctrl_o.alu_sel = sel_logic;
                ctrl_o.wd      = rt;
                rd1_o.re       = 1'b1;
                imm_o          = {{(`MIPS_DATA_W-`MIPS_IMM_W){1'b0}}, imm16};
                case (op)
                    op_ori:  ctrl_o.alu_op = alu_or;
                    op_andi: ctrl_o.alu_op = alu_and;
                    default: ctrl_o.alu_op = alu_xor;
                endcase
            end
            // lui is an or with the immediate in the upper half
            op_lui: begin
                ctrl_o.wreg    = 1'b1;
                ctrl_o.alu_op  = alu_or;
                ctrl_o.alu_sel = sel_logic;
                ctrl_o.wd      = rt;
                rd1_o.re       = 1'b1;
                imm_o          = {imm16, {(`MIPS_DATA_W-`MIPS_IMM_W){1'b0}}};
            end
            // no cache yet, prefetch does nothing
            op_pref: begin
                ctrl_o.wreg = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mips_pkg.sv */
`include "mips_consts.svh"

`default_nettype none

package mips_pkg;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_pref    = 6'b110011
    } opcode_e;

    // function code of special instructions, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'b000000,
        fn_srl  = 6'b000010,
        fn_sra  = 6'b000011,
        fn_sllv = 6'b000100,
        fn_srlv = 6'b000110,
        fn_srav = 6'b000111,
        fn_sync = 6'b001111,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110,
        fn_nor  = 6'b100111
    } funct_e;

    // operation subtype seen by the ALU
    typedef enum logic [7:0] {
        alu_nop = 8'b00000000,
        alu_srl = 8'b00000010,
        alu_sra = 8'b00000011,
        alu_and = 8'b00100100,
        alu_or  = 8'b00100101,
        alu_xor = 8'b00100110,
        alu_nor = 8'b00100111,
        alu_sll = 8'b01111100
    } alu_op_e;

    // result class, picks the EX result mux
    typedef enum logic [2:0] {
        sel_nop   = 3'b000,
        sel_logic = 3'b001,
        sel_shift = 3'b010
    } alu_sel_e;

    // one register file read port request
    typedef struct packed {
        logic                        re;
        logic [`MIPS_REG_ADDR_W-1:0] addr;
    } rf_read_t;

    // pending register write from a later stage
    typedef struct packed {
        logic                        we;
        logic [`MIPS_REG_ADDR_W-1:0] waddr;
        logic [`MIPS_DATA_W-1:0]     wdata;
    } wb_fwd_t;

    // control half of ID/EX
    typedef struct packed {
        alu_op_e                     alu_op;
        alu_sel_e                    alu_sel;
        logic [`MIPS_REG_ADDR_W-1:0] wd;
        logic                        wreg;
    } ex_ctrl_t;

endpackage

`default_nettype wire

/* hdl/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath widths
`define MIPS_DATA_W 32
`define MIPS_INST_W 32

// register file addressing
`define MIPS_REG_ADDR_W 5

// immediate and shift amount fields
`define MIPS_IMM_W 16
`define MIPS_SHAMT_W 5

// instruction field positions, lsb of each field
//   R-type: | op | rs | rt | rd | shamt | funct |
//   I-type: | op | rs | rt | immediate          |
`define MIPS_RS_LSB 21
`define MIPS_RT_LSB 16
`define MIPS_RD_LSB 11
`define MIPS_SHAMT_LSB 6
`define MIPS_OP_LSB 26

// $zero, also the destination of a bubble
`define MIPS_NOP_REG 5'd0

`endif
